/* logic/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN      32
`define REG_IDX_W 5
`define RESET_PC  32'h0000_0000

// Major opcodes.
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011

// ALU funct3, shared by OP and OP_IMM.
`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111

// Load and store widths.
`define F3_LB  3'b000
`define F3_LH  3'b001
`define F3_LW  3'b010
`define F3_LBU 3'b100
`define F3_LHU 3'b101
`define F3_SB  3'b000
`define F3_SH  3'b001
`define F3_SW  3'b010

`endif

/* logic/rv_pkg.sv */
`include "rv_consts.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`XLEN/8-1:0]    byte_en_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B // Used by lui.
    } alu_op_t;

    // Bit 2 is the unsigned flag, bits 1:0 the access size, as in funct3.
    typedef enum logic [2:0] {
        MEM_B  = `F3_LB,
        MEM_H  = `F3_LH,
        MEM_W  = `F3_LW,
        MEM_BU = `F3_LBU,
        MEM_HU = `F3_LHU
    } mem_size_t;

    typedef struct packed {
        logic      valid;
        reg_idx_t  rd;
        reg_idx_t  rs1;      // Zero when the format has no rs1.
        reg_idx_t  rs2;      // Zero when the format has no rs2.
        alu_op_t   alu_op;
        logic      a_is_pc;
        logic      b_is_imm;
        logic      mem_read;
        logic      mem_write;
        mem_size_t mem_size;
        logic      reg_write;
    } ctrl_word_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        word_t      alu_result; // Also the byte address for loads and stores.
        word_t      store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     reg_write;
        word_t    result;
    } mem_wb_t;

endpackage

/* logic/decoder.sv */
`include "rv_consts.svh"

module decoder import rv_pkg::*; (
    input  word_t      instr,
    output ctrl_word_t ctrl,
    output word_t      imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            `F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            `F3_SLL:     op = ALU_SLL;
            `F3_SLT:     op = ALU_SLT;
            `F3_SLTU:    op = ALU_SLTU;
            `F3_XOR:     op = ALU_XOR;
            `F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            `F3_OR:      op = ALU_OR;
            `F3_AND:     op = ALU_AND;
            default:     op = ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl       = '0;
        ctrl.valid = 1'b1;
        imm        = '0;
        legal      = 1'b1;
        case (opcode)
            `OPC_OP: begin
                ctrl.rd        = instr[11:7];
                ctrl.rs1       = instr[19:15];
                ctrl.rs2       = instr[24:20];
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_decode(funct3, funct7[5]);
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 &&
                         (funct3 == `F3_ADD_SUB || funct3 == `F3_SRL_SRA));
            end
            `OPC_OP_IMM: begin
                ctrl.rd        = instr[11:7];
                ctrl.rs1       = instr[19:15];
                ctrl.reg_write = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                ctrl.alu_op    = alu_decode(funct3, funct7[5] && funct3 == `F3_SRL_SRA);
                imm            = {{20{instr[31]}}, instr[31:20]};
                if (funct3 == `F3_SLL) begin
                    legal = (funct7 == 7'b0000000);
                end else if (funct3 == `F3_SRL_SRA) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end
            end
            `OPC_LUI, `OPC_AUIPC: begin
                ctrl.rd        = instr[11:7];
                ctrl.reg_write = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                ctrl.a_is_pc   = (opcode == `OPC_AUIPC);
                ctrl.alu_op    = (opcode == `OPC_AUIPC) ? ALU_ADD : ALU_PASS_B;
                imm            = {instr[31:12], 12'b0};
            end
            `OPC_LOAD: begin
                ctrl.rd        = instr[11:7];
                ctrl.rs1       = instr[19:15];
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                ctrl.alu_op    = ALU_ADD; // Address is rs1 plus offset.
                ctrl.mem_size  = mem_size_t'(funct3);
                imm            = {{20{instr[31]}}, instr[31:20]};
                legal = (funct3 == `F3_LB) || (funct3 == `F3_LH) || (funct3 == `F3_LW) ||
                        (funct3 == `F3_LBU) || (funct3 == `F3_LHU);
            end
            `OPC_STORE: begin
                ctrl.rs1       = instr[19:15];
                ctrl.rs2       = instr[24:20];
                ctrl.mem_write = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                ctrl.alu_op    = ALU_ADD;
                ctrl.mem_size  = mem_size_t'(funct3);
                imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                legal = (funct3 == `F3_SB) || (funct3 == `F3_SH) || (funct3 == `F3_SW);
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            ctrl = '0; // Bubble with no side effects.
        end
    end

endmodule

/* logic/regfile.sv */
module regfile import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr_a,
    input  reg_idx_t raddr_b,
    output word_t    rdata_a,
    output word_t    rdata_b
);

    word_t regs [1:31]; // x0 has no storage.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through so decode sees the value retiring this cycle.
    assign rdata_a = (raddr_a == '0) ? '0 :
                     (we && raddr_a == waddr) ? wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 :
                     (we && raddr_b == waddr) ? wdata : regs[raddr_b];

endmodule

/* logic/execute.sv */
`include "rv_consts.svh"

module execute import rv_pkg::*; (
    input  ctrl_word_t ctrl,
    input  word_t      pc,
    input  word_t      imm,
    input  word_t      rs1_val,
    input  word_t      rs2_val,
    input  mem_wb_t    mem_fwd,
    input  mem_wb_t    wb_fwd,
    output word_t      alu_result,
    output word_t      store_data
);

    localparam int SHAMT_W = $clog2(`XLEN);

    word_t              rs1_fwd;
    word_t              rs2_fwd;
    word_t              op_a;
    word_t              op_b;
    logic [SHAMT_W-1:0] shamt;

    function automatic logic src_hit(input mem_wb_t src, input reg_idx_t idx);
        return src.valid && src.reg_write && (src.rd != '0) && (src.rd == idx);
    endfunction

    // The younger memory-stage result has priority over writeback.
    function automatic word_t fwd_select(input reg_idx_t idx, input word_t rf_val,
                                         input mem_wb_t mem_src, input mem_wb_t wb_src);
        word_t val;
        if (src_hit(mem_src, idx)) begin
            val = mem_src.result;
        end else if (src_hit(wb_src, idx)) begin
            val = wb_src.result;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign rs1_fwd = fwd_select(ctrl.rs1, rs1_val, mem_fwd, wb_fwd);
    assign rs2_fwd = fwd_select(ctrl.rs2, rs2_val, mem_fwd, wb_fwd);

    assign op_a  = ctrl.a_is_pc  ? pc  : rs1_fwd; // PC for auipc.
    assign op_b  = ctrl.b_is_imm ? imm : rs2_fwd;
    assign shamt = op_b[SHAMT_W-1:0];

    // ******************************
    // ALU
    // ******************************
    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SLT:    alu_result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_result = word_t'(op_a < op_b);
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = word_t'($signed(op_a) >>> shamt);
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    assign store_data = rs2_fwd; // Stores need the forwarded rs2 as well.

endmodule

/* logic/mem_align.sv */
`include "rv_consts.svh"

module mem_align import rv_pkg::*; (
    input  ex_mem_t  ex_mem,
    input  word_t    rdata,
    output word_t    wdata,
    output byte_en_t mbe,
    output word_t    result
);

    logic [1:0] offset;
    word_t      byte_lane;
    word_t      half_lane;
    logic [7:0] load_byte;
    logic [15:0] load_half;

    assign offset = ex_mem.alu_result[1:0];

    // ******************************
    // Store lane steering
    // ******************************
    always_comb begin
        wdata = ex_mem.store_data;
        mbe   = '1;
        if (ex_mem.ctrl.mem_write) begin
            case (ex_mem.ctrl.mem_size)
                MEM_B: begin
                    wdata = ex_mem.store_data << {offset, 3'b000};
                    mbe   = byte_en_t'(4'b0001) << offset;
                end
                MEM_H: begin
                    wdata = ex_mem.store_data << {offset[1], 4'b0000};
                    mbe   = byte_en_t'(4'b0011) << {offset[1], 1'b0};
                end
                default: begin
                    wdata = ex_mem.store_data;
                    mbe   = '1;
                end
            endcase
        end
    end

    // ******************************
    // Load extraction
    // ******************************
    assign byte_lane = rdata >> {offset, 3'b000};
    assign half_lane = rdata >> {offset[1], 4'b0000};
    assign load_byte = byte_lane[7:0];
    assign load_half = half_lane[15:0];

    always_comb begin
        result = ex_mem.alu_result; // Non-loads pass the ALU result.
        if (ex_mem.ctrl.mem_read) begin
            case (ex_mem.ctrl.mem_size)
                MEM_B:   result = {{(`XLEN-8){load_byte[7]}}, load_byte};
                MEM_BU:  result = {{(`XLEN-8){1'b0}}, load_byte};
                MEM_H:   result = {{(`XLEN-16){load_half[15]}}, load_half};
                MEM_HU:  result = {{(`XLEN-16){1'b0}}, load_half};
                default: result = rdata;
            endcase
        end
    end

endmodule

/* logic/datapath.sv */
`include "rv_consts.svh"

module datapath import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    output word_t    inst_addr,
    input  word_t    inst_rdata,
    output logic     data_read,
    output logic     data_write,
    output word_t    data_addr,
    output byte_en_t data_mbe,
    output word_t    data_wdata,
    input  word_t    data_rdata
);

    word_t      pc;
    logic       if_id_valid;
    word_t      if_id_instr;
    word_t      if_id_pc;
    ctrl_word_t dec_ctrl;
    word_t      dec_imm;
    word_t      rf_rdata_a;
    word_t      rf_rdata_b;
    ctrl_word_t id_ex_ctrl;
    word_t      id_ex_pc;
    word_t      id_ex_imm;
    word_t      id_ex_rs1;
    word_t      id_ex_rs2;
    word_t      ex_alu_result;
    word_t      ex_store_data;
    ex_mem_t    ex_mem;
    word_t      mem_result;
    mem_wb_t    mem_fwd;
    mem_wb_t    mem_wb;

    // ******************************
    // Fetch
    // ******************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= `RESET_PC;
            if_id_valid <= 1'b0;
        end else begin
            pc          <= pc + word_t'(4); // No control flow.
            if_id_valid <= 1'b1;
        end
    end

    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if_id_instr <= inst_rdata;
        if_id_pc    <= pc;
    end

    // ******************************
    // Decode
    // ******************************
    decoder u_decoder (.instr(if_id_instr), .ctrl(dec_ctrl), .imm(dec_imm));

    regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (mem_wb.valid && mem_wb.reg_write),
        .waddr   (mem_wb.rd),
        .wdata   (mem_wb.result),
        .raddr_a (dec_ctrl.rs1),
        .raddr_b (dec_ctrl.rs2),
        .rdata_a (rf_rdata_a),
        .rdata_b (rf_rdata_b)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex_ctrl <= '0;
        end else begin
            id_ex_ctrl <= if_id_valid ? dec_ctrl : '0; // Drop the word fetched in reset.
        end
    end

    always_ff @(posedge clk) begin
        id_ex_pc  <= if_id_pc;
        id_ex_imm <= dec_imm;
        id_ex_rs1 <= rf_rdata_a;
        id_ex_rs2 <= rf_rdata_b;
    end

    // ******************************
    // Execute
    // ******************************
    execute u_execute (
        .ctrl       (id_ex_ctrl),
        .pc         (id_ex_pc),
        .imm        (id_ex_imm),
        .rs1_val    (id_ex_rs1),
        .rs2_val    (id_ex_rs2),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (mem_wb),
        .alu_result (ex_alu_result),
        .store_data (ex_store_data)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= '{ctrl: id_ex_ctrl, alu_result: ex_alu_result,
                        store_data: ex_store_data};
        end
    end

    // ******************************
    // Memory and writeback
    // ******************************
    mem_align u_mem_align (
        .ex_mem (ex_mem),
        .rdata  (data_rdata),
        .wdata  (data_wdata),
        .mbe    (data_mbe),
        .result (mem_result)
    );

    assign data_read  = ex_mem.ctrl.valid && ex_mem.ctrl.mem_read;
    assign data_write = ex_mem.ctrl.valid && ex_mem.ctrl.mem_write;
    assign data_addr  = {ex_mem.alu_result[`XLEN-1:2], 2'b00};

    assign mem_fwd = '{valid: ex_mem.ctrl.valid, rd: ex_mem.ctrl.rd,
                       reg_write: ex_mem.ctrl.reg_write, result: mem_result};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= mem_fwd; // Same payload feeds forwarding and the register file.
        end
    end

endmodule

/* verif/tb_clk.sv */
module tb_clk (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // Period of 10.
    end

    // Reset covers four rising edges and is released on a falling edge.
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* verif/tb_top.sv */
`include "rv_consts.svh"

module tb_top import rv_pkg::*; ();

    localparam int MEM_WORDS = 256;
    localparam int MAX_STORES = 64;

    logic     clk;
    logic     rst_n;
    word_t    inst_addr;
    word_t    inst_rdata;
    logic     data_read;
    logic     data_write;
    word_t    data_addr;
    byte_en_t data_mbe;
    word_t    data_wdata;
    word_t    data_rdata;

    word_t    imem [0:MEM_WORDS-1];
    word_t    dmem [0:MEM_WORDS-1];
    word_t    exp_addr [0:MAX_STORES-1];
    byte_en_t exp_mbe [0:MAX_STORES-1];
    word_t    exp_data [0:MAX_STORES-1];
    int       store_count = 0;
    int       store_next = 0;
    int       inst_count = 0;
    word_t    last_inst_addr = '0;
    int       cycles_out = 0; // Rising edges since reset was released.
    logic     loaded = 1'b0;

    tb_clk u_clk (.clk(clk), .rst_n(rst_n));

    datapath u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_mbe   (data_mbe),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata)
    );

    // Both memories answer in the same cycle.
    assign inst_rdata = imem[inst_addr[9:2]];
    assign data_rdata = data_read ? dmem[data_addr[9:2]] : '0; // Driven only under the read strobe.

    // ******************************
    // Failure reporting
    // ******************************
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "Run stopped on error.");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure("Value mismatch.");
        end
    endtask

    task automatic check_mbe(input string name, input byte_en_t got, input byte_en_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_with_failure("Byte enable mismatch.");
        end
    endtask

    function automatic word_t lane_mask(input byte_en_t mbe);
        word_t m;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{mbe[i]}};
        end
        return m;
    endfunction

    // ******************************
    // Golden file loading
    // ******************************
    task automatic load_golden();
        int    fd;
        int    n;
        string line;
        string rest;
        word_t a;
        word_t b;
        word_t c;
        fd = $fopen("verif/golden_program.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open verif/golden_program.txt.");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 3 || line.getc(0) == "#") begin
                continue;
            end
            rest = line.substr(2, line.len() - 1);
            a = '0;
            b = '0;
            c = '0;
            n = $sscanf(rest, "%h %h %h", a, b, c);
            case (line.getc(0))
                "I": begin
                    imem[a[9:2]] = b;
                    inst_count++;
                    if (a > last_inst_addr) begin
                        last_inst_addr = a;
                    end
                end
                "D": dmem[a[9:2]] = b;
                "W": begin
                    exp_addr[store_count] = a;
                    exp_mbe[store_count]  = b[3:0];
                    exp_data[store_count] = c;
                    store_count++;
                end
                default: stop_with_failure("Unknown line tag in the golden file.");
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        void'($urandom(32'hc4a7));
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = 32'h0000_0013; // addi x0, x0, 0.
            dmem[i] = $urandom;      // Untouched words hold noise.
        end
        load_golden();
        @(posedge clk); // The PC is known only after the first edge in reset.
        loaded = 1'b1;
    end

    // ******************************
    // Memory writes and monitoring
    // ******************************
    always @(posedge clk) begin
        if (rst_n && data_write) begin
            for (int i = 0; i < 4; i++) begin
                if (data_mbe[i]) begin
                    dmem[data_addr[9:2]][8*i +: 8] <= data_wdata[8*i +: 8];
                end
            end
        end
        if (!rst_n) begin
            cycles_out <= 0;
        end else begin
            cycles_out <= cycles_out + 1;
        end
    end

    always @(negedge clk) begin
        word_t mask;
        if (loaded) begin
            check_word("inst_addr", inst_addr, word_t'(`RESET_PC + 4 * cycles_out));
            if (cycles_out <= 1) begin
                check_word("data_read", word_t'(data_read), '0);
                check_word("data_write", word_t'(data_write), '0);
            end
            if (data_write) begin
                if (store_next >= store_count) begin
                    stop_with_failure("A store appeared with no expected store left.");
                end
                mask = lane_mask(exp_mbe[store_next]);
                check_word("data_addr", data_addr, exp_addr[store_next]);
                check_mbe("data_mbe", data_mbe, exp_mbe[store_next]);
                check_word("data_wdata", data_wdata & mask, exp_data[store_next] & mask);
                store_next++;
            end
            if (cycles_out > 0 && inst_addr > last_inst_addr + word_t'(20)) begin
                if (store_next == store_count) begin
                    $display("** PASS **");
                    $finish;
                end else begin
                    $display("Only %0d of %0d expected stores were seen.",
                             store_next, store_count);
                    stop_with_failure("The program ended with stores missing.");
                end
            end
        end
    end

    // Watchdog sized from the program length.
    initial begin
        wait (loaded);
        #((inst_count + 20) * 10);
        stop_with_failure("Timeout before the program finished.");
    end

endmodule

/* verif/golden_program.txt */
# I <byte addr> <instruction> | D <byte addr> <data word>
# W <word addr> <byte enables> <lane data> for each expected store, in order
D 00000000 8765F3A1
I 00000000 12300093
I 00000004 FFB00113
I 00000008 002081B3
I 0000000C 04302023
I 00000010 40208233
I 00000014 0020F2B3
I 00000018 04402223
I 0000001C 04502423
I 00000020 0020C333
I 00000024 001123B3
I 00000028 00113433
I 0000002C 04602623
I 00000030 04702823
I 00000034 04802A23
I 00000038 00411493
I 0000003C 4024D513
I 00000040 0084D593
I 00000044 04A02C23
I 00000048 04B02E23
I 0000004C ABCDE637
I 00000050 00001697
I 00000054 06C02023
I 00000058 06D02223
I 0000005C 00166733
I 00000060 00708013
I 00000064 06002423
I 00000068 06E00823
I 0000006C 06E00AA3
I 00000070 06E00D23
I 00000074 06E00FA3
I 00000078 08E01023
I 0000007C 08E01323
I 00000080 00100783
I 00000084 00178833
I 00000088 09002423
I 0000008C 00104783
I 00000090 00178833
I 00000094 09002623
I 00000098 00201783
I 0000009C 00178833
I 000000A0 09002823
I 000000A4 00205783
I 000000A8 00178833
I 000000AC 09002A23
I 000000B0 00002783
I 000000B4 00178833
I 000000B8 09002C23
W 00000040 f 0000011E
W 00000044 f 00000128
W 00000048 f 00000123
W 0000004C f FFFFFED8
W 00000050 f 00000001
W 00000054 f 00000000
W 00000058 f FFFFFFEC
W 0000005C f 00FFFFFF
W 00000060 f ABCDE000
W 00000064 f 00001050
W 00000068 f 00000000
W 00000070 1 00000023
W 00000074 2 00002300
W 00000078 4 00230000
W 0000007C 8 23000000
W 00000080 3 0000E123
W 00000084 c E1230000
W 00000088 f 00000116
W 0000008C f 00000216
W 00000090 f FFFF8888
W 00000094 f 00008888
W 00000098 f 8765F4C4

/* tb.f */
+incdir+logic
logic/rv_pkg.sv
logic/decoder.sv
logic/regfile.sv
logic/execute.sv
logic/mem_align.sv
logic/datapath.sv
verif/tb_clk.sv
verif/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_top -f tb.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

echo "Simulation finished"
exit 0
